// File: hw/ahb_pkg.sv
package ahb_pkg;

  typedef logic [31:0] haddr_t;
  typedef logic [31:0] hdata_t;
  typedef logic [1:0]  htrans_t;

  // HTRANS encodings
  localparam htrans_t TRANS_IDLE   = 2'b00;
  localparam htrans_t TRANS_BUSY   = 2'b01;  // Handled as IDLE
  localparam htrans_t TRANS_NONSEQ = 2'b10;
  localparam htrans_t TRANS_SEQ    = 2'b11;  // Handled as NONSEQ

  // Slot select sits in haddr[17:16], 64 KiB per slot
  typedef logic [1:0] slot_t;

  localparam int SLOT_LSB  = 16;
  localparam int NUM_SLOTS = 4;

  localparam slot_t SLOT_SEG7 = 2'd1;

endpackage

// File: hw/seg7_pkg.sv
package seg7_pkg;

  localparam int NUM_DIGITS = 8;

  typedef logic [4:0] digit_val_t;    // [3:0] hex value, [4] decimal point
  typedef logic [7:0] seg_pattern_t;  // Common anode, active low, [7] is dp
  typedef logic [7:0] digit_sel_t;    // One-hot, active high

  // Register byte offsets within the slot
  localparam logic [15:0] DIGIT_BASE  = 16'h0000;
  localparam logic [15:0] CTRL_OFFSET = 16'h0020;

  function automatic seg_pattern_t hex_to_seg(input digit_val_t val);
    seg_pattern_t pat;
    case (val[3:0])
      4'h0: pat = 8'hC0;
      4'h1: pat = 8'hF9;
      4'h2: pat = 8'hA4;
      4'h3: pat = 8'hB0;
      4'h4: pat = 8'h99;
      4'h5: pat = 8'h92;
      4'h6: pat = 8'h82;
      4'h7: pat = 8'hF8;
      4'h8: pat = 8'h80;
      4'h9: pat = 8'h90;
      4'hA: pat = 8'h88;
      4'hB: pat = 8'h83;
      4'hC: pat = 8'hC6;
      4'hD: pat = 8'hA1;
      4'hE: pat = 8'h86;
      default: pat = 8'h8E;
    endcase
    pat[7] = ~val[4];  // Point lit when low
    return pat;
  endfunction

endpackage

// File: hw/ahb_slot_decoder.sv
`timescale 1ns/1ps

module ahb_slot_decoder (
  input  logic                            CLK_FPGA_SYS1,
  input  logic                            sys_rst_n,
  input  logic                            hsel,
  input  ahb_pkg::haddr_t                 haddr,
  input  ahb_pkg::htrans_t                htrans,
  input  logic [ahb_pkg::NUM_SLOTS-1:0]   hreadyout_slot,
  input  ahb_pkg::hdata_t [ahb_pkg::NUM_SLOTS-1:0] hrdata_slot,
  input  logic [ahb_pkg::NUM_SLOTS-1:0]   hresp_slot,
  output logic [ahb_pkg::NUM_SLOTS-1:0]   hsel_slot,
  output logic                            hready,
  output ahb_pkg::hdata_t                 hrdata,
  output logic                            hresp
);
  import ahb_pkg::*;

  slot_t addr_slot;
  slot_t data_slot_q;
  logic  active;

  assign addr_slot = haddr[SLOT_LSB +: $bits(slot_t)];
  assign active    = hsel && (htrans == TRANS_NONSEQ || htrans == TRANS_SEQ);

  always_comb
  begin
    hsel_slot            = '0;
    hsel_slot[addr_slot] = hsel;
  end

  // Data-phase owner follows every completed address phase
  always_ff @(posedge CLK_FPGA_SYS1 or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
      data_slot_q <= slot_t'(0);
    else if (hready)
      data_slot_q <= active ? addr_slot : slot_t'(0);  // Idle parks on slot 0
  end

  // Response back to the master
  assign hready = hreadyout_slot[data_slot_q];
  assign hrdata = hrdata_slot[data_slot_q];
  assign hresp  = hresp_slot[data_slot_q];

endmodule

// File: hw/ahb_default_slave.sv
`timescale 1ns/1ps

module ahb_default_slave (
  input  logic             CLK_FPGA_SYS1,
  input  logic             sys_rst_n,
  input  logic             hsel,
  input  ahb_pkg::htrans_t htrans,
  input  logic             hready,
  output logic             hreadyout,
  output ahb_pkg::hdata_t  hrdata,
  output logic             hresp
);
  import ahb_pkg::*;

  typedef enum logic [1:0] {RESP_OKAY, RESP_ERR1, RESP_ERR2} resp_state_t;

  resp_state_t state_q;
  logic        active;
  logic        accept;

  always_comb
  begin
    case (htrans)
      TRANS_NONSEQ, TRANS_SEQ: active = 1'b1;
      TRANS_IDLE, TRANS_BUSY:  active = 1'b0;
      default:                 active = 1'b0;
    endcase
  end

  assign accept = hsel && hready && active;

  always_ff @(posedge CLK_FPGA_SYS1 or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
      state_q <= RESP_OKAY;
    else
    begin
      case (state_q)
        RESP_OKAY: state_q <= accept ? RESP_ERR1 : RESP_OKAY;
        RESP_ERR1: state_q <= RESP_ERR2;
        RESP_ERR2: state_q <= accept ? RESP_ERR1 : RESP_OKAY;  // Back to back errors
        default:   state_q <= RESP_OKAY;
      endcase
    end
  end

  assign hreadyout = (state_q != RESP_ERR1);  // Wait only in first error cycle
  assign hresp     = (state_q != RESP_OKAY);
  assign hrdata    = '0;

endmodule

// File: hw/seg7_regs.sv
`timescale 1ns/1ps

module seg7_regs (
  input  logic                                         CLK_FPGA_SYS1,
  input  logic                                         sys_rst_n,
  input  logic                                         hsel,
  input  ahb_pkg::haddr_t                              haddr,
  input  ahb_pkg::htrans_t                             htrans,
  input  logic                                         hwrite,
  input  ahb_pkg::hdata_t                              hwdata,
  input  logic                                         hready,
  output logic                                         hreadyout,
  output ahb_pkg::hdata_t                              hrdata,
  output logic                                         hresp,
  output seg7_pkg::digit_val_t [seg7_pkg::NUM_DIGITS-1:0] digit_vals,
  output logic                                         display_en
);
  import ahb_pkg::*;
  import seg7_pkg::*;

  localparam int IDX_W = $clog2(NUM_DIGITS);

  logic [SLOT_LSB-1:0] offset_q;
  logic                write_q;
  logic                active;
  logic                digit_hit;
  logic                ctrl_hit;
  logic [IDX_W-1:0]    digit_idx;

  assign active = hsel && (htrans == TRANS_NONSEQ || htrans == TRANS_SEQ);

  // Address phase capture
  always_ff @(posedge CLK_FPGA_SYS1 or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      offset_q <= '0;
      write_q  <= 1'b0;
    end
    else if (hready)
    begin
      offset_q <= haddr[SLOT_LSB-1:0];
      write_q  <= active && hwrite;
    end
  end

  // Word decode, byte lanes ignored
  assign digit_hit = (offset_q[SLOT_LSB-1:IDX_W+2] == DIGIT_BASE[SLOT_LSB-1:IDX_W+2]);
  assign ctrl_hit  = (offset_q[SLOT_LSB-1:2] == CTRL_OFFSET[SLOT_LSB-1:2]);
  assign digit_idx = offset_q[IDX_W+1:2];

  always_ff @(posedge CLK_FPGA_SYS1 or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      digit_vals <= '0;
      display_en <= 1'b0;
    end
    else if (write_q && hready)
    begin
      if (digit_hit)
        digit_vals[digit_idx] <= hwdata[$bits(digit_val_t)-1:0];
      else if (ctrl_hit)
        display_en <= hwdata[0];
    end
  end

  always_comb
  begin
    hrdata = '0;  // Unmapped offsets
    if (digit_hit)
      hrdata = hdata_t'(digit_vals[digit_idx]);
    else if (ctrl_hit)
      hrdata = hdata_t'(display_en);
  end

  assign hreadyout = 1'b1;
  assign hresp     = 1'b0;

endmodule

// File: hw/seg7_shifter.sv
`timescale 1ns/1ps

module seg7_shifter #(
  parameter int SHIFT_DIV = 4
) (
  input  logic                                         CLK_FPGA_SYS1,
  input  logic                                         sys_rst_n,
  input  seg7_pkg::digit_val_t [seg7_pkg::NUM_DIGITS-1:0] digit_vals,
  input  logic                                         display_en,
  output logic                                         seg7_sh_cp,
  output logic                                         seg7_st_cp,
  output logic                                         seg7_ds
);
  import seg7_pkg::*;

  localparam int DIV_W   = (SHIFT_DIV > 1) ? $clog2(SHIFT_DIV) : 1;
  localparam int DIGIT_W = $clog2(NUM_DIGITS);
  localparam int FRAME_W = $bits(seg_pattern_t) + $bits(digit_sel_t);
  localparam int BIT_W   = $clog2(FRAME_W);

  typedef enum logic [1:0] {LOAD, SHIFT_LOW, SHIFT_HIGH, LATCH} shift_state_t;

  shift_state_t       state_q;
  logic [DIV_W-1:0]   div_q;
  logic [BIT_W-1:0]   bit_q;
  logic [DIGIT_W-1:0] digit_q;
  logic [FRAME_W-1:0] frame_q;
  logic [FRAME_W-1:0] frame_new;
  seg_pattern_t       seg_byte;
  digit_sel_t         sel_byte;
  logic               div_done;

  assign div_done = (div_q == DIV_W'(SHIFT_DIV - 1));

  always_comb
  begin
    seg_byte  = display_en ? hex_to_seg(digit_vals[digit_q]) : '1;  // Blank when off
    sel_byte  = digit_sel_t'(1) << digit_q;
    frame_new = {seg_byte, sel_byte};
  end

  // LOAD is also the first low cycle of the MSB
  always_ff @(posedge CLK_FPGA_SYS1 or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      state_q <= LOAD;
      div_q   <= '0;
      bit_q   <= '0;
      digit_q <= '0;
    end
    else
    begin
      case (state_q)
        LOAD:
        begin
          bit_q   <= '0;
          digit_q <= (digit_q == DIGIT_W'(NUM_DIGITS - 1)) ? '0 : digit_q + 1'b1;
          if (SHIFT_DIV > 1)
          begin
            state_q <= SHIFT_LOW;
            div_q   <= DIV_W'(1);
          end
          else
          begin
            state_q <= SHIFT_HIGH;
            div_q   <= '0;
          end
        end
        SHIFT_LOW:
        begin
          div_q <= div_done ? '0 : div_q + 1'b1;
          if (div_done)
            state_q <= SHIFT_HIGH;
        end
        SHIFT_HIGH:
        begin
          div_q <= div_done ? '0 : div_q + 1'b1;
          if (div_done && bit_q == BIT_W'(FRAME_W - 1))
            state_q <= LATCH;
          else if (div_done)
          begin
            bit_q   <= bit_q + 1'b1;
            state_q <= SHIFT_LOW;
          end
        end
        default:
        begin
          div_q <= div_done ? '0 : div_q + 1'b1;
          if (div_done)
            state_q <= LOAD;
        end
      endcase
    end
  end

  always_ff @(posedge CLK_FPGA_SYS1)
  begin
    if (state_q == LOAD)
      frame_q <= frame_new;
    else if (state_q == SHIFT_HIGH && div_done)
      frame_q <= frame_q << 1;  // Next bit after the rising edge
  end

  assign seg7_sh_cp = (state_q == SHIFT_HIGH);
  assign seg7_st_cp = (state_q == LATCH);
  assign seg7_ds    = (state_q == LOAD) ? frame_new[FRAME_W-1] : frame_q[FRAME_W-1];

endmodule

// File: hw/led_chaser.sv
`timescale 1ns/1ps

module led_chaser #(
  parameter int STEP_CYCLES = 25_000_000
) (
  input  logic       CLK_FPGA_SYS1,
  input  logic       sys_rst_n,
  output logic [1:0] led
);

  localparam int CNT_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;

  logic [CNT_W-1:0] step_q;
  logic             step_done;

  assign step_done = (step_q == CNT_W'(STEP_CYCLES - 1));

  always_ff @(posedge CLK_FPGA_SYS1 or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      step_q <= '0;
      led    <= 2'b01;
    end
    else if (step_done)
    begin
      step_q <= '0;
      led    <= {led[0], led[1]};  // Swap the pair
    end
    else
      step_q <= step_q + 1'b1;
  end

endmodule

// File: hw/soc_periph_top.sv
`timescale 1ns/1ps

module soc_periph_top #(
  parameter int SHIFT_DIV   = 4,
  parameter int STEP_CYCLES = 25_000_000
) (
  input  logic             CLK_FPGA_SYS1,
  input  logic             rst_n,
  input  logic             hsel,
  input  ahb_pkg::haddr_t  haddr,
  input  ahb_pkg::htrans_t htrans,
  input  logic             hwrite,
  input  ahb_pkg::hdata_t  hwdata,
  output ahb_pkg::hdata_t  hrdata,
  output logic             hready,
  output logic             hresp,
  output logic             seg7_sh_cp,
  output logic             seg7_st_cp,
  output logic             seg7_ds,
  output logic [1:0]       led
);
  import ahb_pkg::*;
  import seg7_pkg::*;

  logic [1:0]                  rst_sync_q;
  logic                        sys_rst_n;
  logic [NUM_SLOTS-1:0]        hsel_slot;
  logic [NUM_SLOTS-1:0]        hreadyout_slot;
  hdata_t [NUM_SLOTS-1:0]      hrdata_slot;
  logic [NUM_SLOTS-1:0]        hresp_slot;
  digit_val_t [NUM_DIGITS-1:0] digit_vals;
  logic                        display_en;

  // Reset release synchronizer, assert is immediate
  always_ff @(posedge CLK_FPGA_SYS1 or negedge rst_n)
  begin
    if (!rst_n)
      rst_sync_q <= 2'b00;
    else
      rst_sync_q <= {rst_sync_q[0], 1'b1};
  end

  assign sys_rst_n = rst_sync_q[1];

  ahb_slot_decoder u_decoder (
    .CLK_FPGA_SYS1  (CLK_FPGA_SYS1),
    .sys_rst_n      (sys_rst_n),
    .hsel           (hsel),
    .haddr          (haddr),
    .htrans         (htrans),
    .hreadyout_slot (hreadyout_slot),
    .hrdata_slot    (hrdata_slot),
    .hresp_slot     (hresp_slot),
    .hsel_slot      (hsel_slot),
    .hready         (hready),
    .hrdata         (hrdata),
    .hresp          (hresp)
  );

  // Every slot but the display answers with an error
  for (genvar s = 0; s < NUM_SLOTS; s++)
  begin : g_slot
    if (s != SLOT_SEG7)
    begin : g_null
      ahb_default_slave u_null (
        .CLK_FPGA_SYS1 (CLK_FPGA_SYS1),
        .sys_rst_n     (sys_rst_n),
        .hsel          (hsel_slot[s]),
        .htrans        (htrans),
        .hready        (hready),
        .hreadyout     (hreadyout_slot[s]),
        .hrdata        (hrdata_slot[s]),
        .hresp         (hresp_slot[s])
      );
    end
  end

  seg7_regs u_seg7_regs (
    .CLK_FPGA_SYS1 (CLK_FPGA_SYS1),
    .sys_rst_n     (sys_rst_n),
    .hsel          (hsel_slot[SLOT_SEG7]),
    .haddr         (haddr),
    .htrans        (htrans),
    .hwrite        (hwrite),
    .hwdata        (hwdata),
    .hready        (hready),
    .hreadyout     (hreadyout_slot[SLOT_SEG7]),
    .hrdata        (hrdata_slot[SLOT_SEG7]),
    .hresp         (hresp_slot[SLOT_SEG7]),
    .digit_vals    (digit_vals),
    .display_en    (display_en)
  );

  seg7_shifter #(
    .SHIFT_DIV (SHIFT_DIV)
  ) u_seg7_shifter (
    .CLK_FPGA_SYS1 (CLK_FPGA_SYS1),
    .sys_rst_n     (sys_rst_n),
    .digit_vals    (digit_vals),
    .display_en    (display_en),
    .seg7_sh_cp    (seg7_sh_cp),
    .seg7_st_cp    (seg7_st_cp),
    .seg7_ds       (seg7_ds)
  );

  led_chaser #(
    .STEP_CYCLES (STEP_CYCLES)
  ) u_led_chaser (
    .CLK_FPGA_SYS1 (CLK_FPGA_SYS1),
    .sys_rst_n     (sys_rst_n),
    .led           (led)
  );

endmodule

// File: bench/tb_ahb_tasks.svh
`ifndef TB_AHB_TASKS_SVH
`define TB_AHB_TASKS_SVH

// Single transfer, address phase then data phase until hready
task automatic ahb_transfer(
  input  haddr_t addr,
  input  logic   write,
  input  hdata_t wdata,
  output hdata_t rdata,
  output logic   resp,
  output int     waits,
  output logic   wait_resp,
  output time    done_t
);
  @(posedge CLK_FPGA_SYS1);
  hsel   <= 1'b1;
  haddr  <= addr;
  htrans <= TRANS_NONSEQ;
  hwrite <= write;
  @(negedge CLK_FPGA_SYS1);
  while (!hready)  // Previous data phase still stalled
    @(negedge CLK_FPGA_SYS1);
  @(posedge CLK_FPGA_SYS1);
  hsel   <= 1'b0;
  htrans <= TRANS_IDLE;
  hwrite <= 1'b0;
  hwdata <= write ? wdata : '0;
  waits     = 0;
  wait_resp = 1'b0;
  @(negedge CLK_FPGA_SYS1);
  while (!hready)
  begin
    waits++;
    wait_resp = hresp;
    @(negedge CLK_FPGA_SYS1);
  end
  rdata  = hrdata;
  resp   = hresp;
  done_t = $time;  // Completing edge follows
endtask

task automatic ahb_write(
  input  haddr_t addr,
  input  hdata_t wdata,
  output logic   resp,
  output int     waits,
  output logic   wait_resp,
  output time    done_t
);
  hdata_t unused_rdata;
  ahb_transfer(addr, 1'b1, wdata, unused_rdata, resp, waits, wait_resp, done_t);
endtask

task automatic ahb_read(
  input  haddr_t addr,
  output hdata_t rdata,
  output logic   resp,
  output int     waits,
  output logic   wait_resp,
  output time    done_t
);
  ahb_transfer(addr, 1'b0, '0, rdata, resp, waits, wait_resp, done_t);
endtask

`endif

// File: bench/tb_soc_periph.sv
`timescale 1ns/1ps

module tb_soc_periph;
  import ahb_pkg::*;
  import seg7_pkg::*;

  localparam int SHIFT_DIV       = 2;
  localparam int STEP_CYCLES     = 50;
  localparam int CLK_PERIOD      = 40;
  localparam int RST_CYCLES      = 16;
  localparam int N_ENTRIES       = 31;
  localparam int FRAME_CYCLES    = 33 * SHIFT_DIV;
  localparam int WATCHDOG_CYCLES = N_ENTRIES * 20 + 20 * FRAME_CYCLES + RST_CYCLES;

  // Common-anode codes with digit F in the top byte
  localparam logic [16*8-1:0] SEG_CODES = {
    8'h8E, 8'h86, 8'hA1, 8'hC6, 8'h83, 8'h88, 8'h90, 8'h80,
    8'hF8, 8'h82, 8'h92, 8'h99, 8'hB0, 8'hA4, 8'hF9, 8'hC0
  };

  logic       CLK_FPGA_SYS1 = 1'b0;
  logic       rst_n;
  logic       hsel;
  haddr_t     haddr;
  htrans_t    htrans;
  logic       hwrite;
  hdata_t     hwdata;
  hdata_t     hrdata;
  logic       hready;
  logic       hresp;
  logic       seg7_sh_cp;
  logic       seg7_st_cp;
  logic       seg7_ds;
  logic [1:0] led;

  haddr_t tab_addr  [N_ENTRIES];
  logic   tab_write [N_ENTRIES];
  hdata_t tab_wdata [N_ENTRIES];
  hdata_t tab_rdata [N_ENTRIES];
  logic   tab_resp  [N_ENTRIES];
  int     fill_idx = 0;

  logic [31:0] lcg_state = 32'h3e99_eb87;
  hdata_t      tr_rdata;
  logic        tr_resp;
  int          tr_waits;
  logic        tr_wait_resp;
  time         tr_done;
  int          frame_base;

  // Display model as seen on the bus
  logic [4:0] exp_dig [NUM_DIGITS];
  logic       exp_en   = 1'b0;
  time        chg_time = 0;

  logic        mon_on = 1'b0;
  logic        prev_sh = 1'b0;
  logic        prev_st = 1'b0;
  logic [15:0] frame_sr = '0;
  int          frame_bits = 0;
  time         frame_start = 0;
  int          prev_digit = 0;
  logic        have_prev_digit = 1'b0;
  int          en_frames = 0;
  int          off_frames = 0;
  logic [1:0]  prev_led = 2'b01;
  int          cycle_cnt = 0;
  int          last_led_cycle = 0;
  int          led_changes = 0;

  `include "tb_ahb_tasks.svh"

  soc_periph_top #(
    .SHIFT_DIV   (SHIFT_DIV),
    .STEP_CYCLES (STEP_CYCLES)
  ) uut (
    .CLK_FPGA_SYS1 (CLK_FPGA_SYS1),
    .rst_n         (rst_n),
    .hsel          (hsel),
    .haddr         (haddr),
    .htrans        (htrans),
    .hwrite        (hwrite),
    .hwdata        (hwdata),
    .hrdata        (hrdata),
    .hready        (hready),
    .hresp         (hresp),
    .seg7_sh_cp    (seg7_sh_cp),
    .seg7_st_cp    (seg7_st_cp),
    .seg7_ds       (seg7_ds),
    .led           (led)
  );

  always #(CLK_PERIOD / 2) CLK_FPGA_SYS1 = ~CLK_FPGA_SYS1;

  task automatic stop_with_failure();
    $display("TB FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic haddr_t seg7_addr(input logic [15:0] off);
    return (haddr_t'(SLOT_SEG7) << SLOT_LSB) | haddr_t'(off);
  endfunction

  function automatic logic [7:0] expected_segments(input logic [4:0] val);
    logic [7:0] pat;
    pat = SEG_CODES[val[3:0] * 8 +: 8];
    if (val[4])
      pat[7] = 1'b0;  // Point on
    return pat;
  endfunction

  task automatic add_entry(input haddr_t addr, input logic write, input hdata_t wdata,
                           input hdata_t rdata, input logic resp);
    tab_addr[fill_idx]  = addr;
    tab_write[fill_idx] = write;
    tab_wdata[fill_idx] = wdata;
    tab_rdata[fill_idx] = rdata;
    tab_resp[fill_idx]  = resp;
    fill_idx++;
  endtask

  task automatic build_table();
    hdata_t wvals [NUM_DIGITS+1];
    for (int d = 0; d < NUM_DIGITS; d++)
      add_entry(seg7_addr(DIGIT_BASE + 16'(4 * d)), 1'b0, '0, '0, 1'b0);
    add_entry(seg7_addr(CTRL_OFFSET), 1'b0, '0, '0, 1'b0);
    for (int d = 0; d <= NUM_DIGITS; d++)
      wvals[d] = next_rand();
    for (int d = 0; d < NUM_DIGITS; d++)
      add_entry(seg7_addr(DIGIT_BASE + 16'(4 * d)), 1'b1, wvals[d], '0, 1'b0);
    add_entry(seg7_addr(CTRL_OFFSET), 1'b1, wvals[NUM_DIGITS], '0, 1'b0);
    for (int d = 0; d < NUM_DIGITS; d++)
      add_entry(seg7_addr(DIGIT_BASE + 16'(4 * d)), 1'b0, '0, {27'b0, wvals[d][4:0]}, 1'b0);
    add_entry(seg7_addr(CTRL_OFFSET), 1'b0, '0, {31'b0, wvals[NUM_DIGITS][0]}, 1'b0);
    add_entry(seg7_addr(16'h0024), 1'b0, '0, '0, 1'b0);  // Unmapped offset
    add_entry(32'h0000_0010, 1'b1, next_rand(), '0, 1'b1);
    add_entry(32'h0002_0004, 1'b0, '0, '0, 1'b1);
    add_entry(32'h0003_0100, 1'b1, next_rand(), '0, 1'b1);
  endtask

  task automatic shadow_update(input haddr_t addr, input hdata_t data, input time t);
    logic [15:0] off;
    off = addr[15:0];
    if (addr[SLOT_LSB +: 2] == SLOT_SEG7)
    begin
      if (off < DIGIT_BASE + 16'h0020)
        exp_dig[off[4:2]] = data[4:0];
      else if (off[15:2] == CTRL_OFFSET[15:2])
        exp_en = data[0];
      chg_time = t;
    end
  endtask

  task automatic seg7_write(input logic [15:0] off, input hdata_t data);
    ahb_write(seg7_addr(off), data, tr_resp, tr_waits, tr_wait_resp, tr_done);
    check_value("hresp", tr_resp, 1'b0);
    check_value("hready wait cycles", tr_waits, 0);
    shadow_update(seg7_addr(off), data, tr_done);
  endtask

  task automatic check_frame();
    logic [7:0] seg;
    logic [7:0] sel;
    int         idx;
    seg = frame_sr[15:8];
    sel = frame_sr[7:0];
    assert (frame_bits == 16)
    else
    begin
      $display("A frame was latched after %0d shift clocks instead of 16", frame_bits);
      stop_with_failure();
    end
    assert ((sel != 8'h00) && ((sel & (sel - 8'd1)) == 8'h00))
    else
    begin
      $display("The frame select byte 0x%h is not one-hot", sel);
      stop_with_failure();
    end
    idx = 0;
    for (int d = 0; d < NUM_DIGITS; d++)
    begin
      if (sel[d])
        idx = d;
    end
    if (have_prev_digit)
      check_value("frame digit index", idx, (prev_digit + 1) % NUM_DIGITS);
    prev_digit      = idx;
    have_prev_digit = 1'b1;
    if (frame_start > chg_time)  // Loaded after the last write
    begin
      if (exp_en)
      begin
        check_value("frame segments", seg, expected_segments(exp_dig[idx]));
        en_frames++;
      end
      else
      begin
        check_value("frame segments", seg, 8'hFF);
        off_frames++;
      end
    end
    frame_bits = 0;
  endtask

  // Frame capture from the shift-register pins
  always @(negedge CLK_FPGA_SYS1)
  begin
    if (rst_n)
    begin
      if (seg7_sh_cp && !prev_sh)
      begin
        frame_sr = {frame_sr[14:0], seg7_ds};
        frame_bits++;
      end
      if (seg7_st_cp && !prev_st)
        check_frame();
      if (!seg7_st_cp && prev_st)
        frame_start = $time;  // LOAD cycle of the next frame
      prev_sh = seg7_sh_cp;
      prev_st = seg7_st_cp;
    end
  end

  always @(negedge CLK_FPGA_SYS1)
  begin
    cycle_cnt++;
    if (mon_on)
    begin
      assert ((led === 2'b01) || (led === 2'b10))
      else
      begin
        $display("[FAIL] led: got 0x%h, expected 0x1 or 0x2", led);
        stop_with_failure();
      end
      if (led !== prev_led)
      begin
        if (led_changes > 0)
          check_value("led step interval", cycle_cnt - last_led_cycle, STEP_CYCLES);
        last_led_cycle = cycle_cnt;
        led_changes++;
      end
      prev_led = led;
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the test sequence finished");
    stop_with_failure();
  end

  initial
  begin
    rst_n  = 1'b0;
    hsel   = 1'b0;
    haddr  = '0;
    htrans = TRANS_IDLE;
    hwrite = 1'b0;
    hwdata = '0;
    for (int d = 0; d < NUM_DIGITS; d++)
      exp_dig[d] = '0;
    build_table();
    repeat (RST_CYCLES) @(posedge CLK_FPGA_SYS1);
    rst_n <= 1'b1;
    repeat (3) @(posedge CLK_FPGA_SYS1);
    mon_on = 1'b1;
    @(negedge CLK_FPGA_SYS1);
    check_value("hready", hready, 1'b1);
    check_value("hresp", hresp, 1'b0);
    check_value("led", led, 2'b01);

    for (int i = 0; i < N_ENTRIES; i++)
    begin
      if (tab_write[i])
      begin
        ahb_write(tab_addr[i], tab_wdata[i], tr_resp, tr_waits, tr_wait_resp, tr_done);
        shadow_update(tab_addr[i], tab_wdata[i], tr_done);
      end
      else
      begin
        ahb_read(tab_addr[i], tr_rdata, tr_resp, tr_waits, tr_wait_resp, tr_done);
        check_value("hrdata", tr_rdata, tab_rdata[i]);
      end
      check_value("hresp", tr_resp, tab_resp[i]);
      check_value("hready wait cycles", tr_waits, tab_resp[i] ? 1 : 0);
      if (tab_resp[i])
        check_value("hresp in wait cycle", tr_wait_resp, 1'b1);
    end

    // Display on with fresh digits and then off
    seg7_write(CTRL_OFFSET, 32'h1);
    for (int d = 0; d < NUM_DIGITS; d++)
      seg7_write(DIGIT_BASE + 16'(4 * d), next_rand());
    frame_base = en_frames;
    while (en_frames < frame_base + NUM_DIGITS)
      @(negedge CLK_FPGA_SYS1);
    seg7_write(CTRL_OFFSET, 32'h0);
    frame_base = off_frames;
    while (off_frames < frame_base + NUM_DIGITS)
      @(negedge CLK_FPGA_SYS1);

    assert (led_changes >= 2)
    begin
      $display("TB PASSED");
      $finish;
    end
    else
    begin
      $display("The LED pattern changed fewer than two times during the run");
      stop_with_failure();
    end
  end

endmodule

// File: files.f
+incdir+bench
hw/ahb_pkg.sv
hw/seg7_pkg.sv
hw/ahb_slot_decoder.sv
hw/ahb_default_slave.sv
hw/seg7_regs.sv
hw/seg7_shifter.sv
hw/led_chaser.sv
hw/soc_periph_top.sv
bench/tb_soc_periph.sv

// File: Bender.yml
package:
  name: soc_periph

sources:
  - files:
      - hw/ahb_pkg.sv
      - hw/seg7_pkg.sv
      - hw/ahb_slot_decoder.sv
      - hw/ahb_default_slave.sv
      - hw/seg7_regs.sv
      - hw/seg7_shifter.sv
      - hw/led_chaser.sv
      - hw/soc_periph_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_soc_periph.sv
